//--- sim.f
common/pg_pkg.sv
hw/raster_counter.sv
hw/tile_divider.sv
hw/pattern_select.sv
hw/pattern_gen.sv
pixel_fifo/pixel_fifo.sv
hw/pg_top.sv
bench/pg_props.sv
bench/tb_pg_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pattern generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert --top-module tb_pg_top -Mdir obj_dir -f sim.f

# the simulator may stop early on an assertion, so the log decides
./obj_dir/Vtb_pg_top | tee sim.log || true

if grep -qx "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- bench/tb_pg_top.sv
/* table-driven testbench for pg_top on a 16x8 raster, FIFO depth 8
   expected pixels come from a model of the pattern rules; out_ready is random */
module tb_pg_top import pg_pkg::*; ();

	localparam int H_ACT      = 16;
	localparam int V_ACT      = 8;
	localparam int CHESS_COLS = 4;
	localparam int CHESS_ROWS = 2;
	localparam int BAR_STEPS  = 8;
	localparam int FIFO_DEPTH = 8;
	localparam int N_TESTS    = 19;
	localparam int PIX_WAIT   = 200;

	logic   clk;
	logic   rst_n;
	logic   frame_start;
	logic   key_up;
	logic   key_down;
	pixel_t out_data;
	logic   out_valid;
	logic   out_ready;

	integer seed;
	int     errors;
	int     failed;
	int     px;
	int     py;

	// stimulus table, one row per test
	string    tst_name [N_TESTS];
	int       n_up     [N_TESTS];
	int       n_down   [N_TESTS];
	bit       both     [N_TESTS];
	bit       fs       [N_TESTS];
	pattern_e exp_pat  [N_TESTS];
	int       n_pix    [N_TESTS];

	pg_top #(
		.H_ACT      (H_ACT),
		.V_ACT      (V_ACT),
		.CHESS_COLS (CHESS_COLS),
		.CHESS_ROWS (CHESS_ROWS),
		.BAR_STEPS  (BAR_STEPS),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_pg_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.key_up      (key_up),
		.key_down    (key_down),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_ready   (out_ready)
	);

	always #2 clk = ~clk;

	task automatic set_row(int i, string name, int up, int down, bit b, bit f,
		pattern_e p, int n);
		tst_name[i] = name;
		n_up[i]     = up;
		n_down[i]   = down;
		both[i]     = b;
		fs[i]       = f;
		exp_pat[i]  = p;
		n_pix[i]    = n;
	endtask

	task automatic load_table;
		set_row(0,  "reset_frame",    0, 0, 0, 0, PAT_FRAME,      128);
		set_row(1,  "up_black",       1, 0, 0, 1, PAT_BLACK,      128);
		set_row(2,  "up_white",       1, 0, 0, 1, PAT_WHITE,      128);
		set_row(3,  "up_blue",        1, 0, 0, 1, PAT_BLUE,       128);
		set_row(4,  "up_chess",       1, 0, 0, 1, PAT_CHESS,      128);
		set_row(5,  "up_chess_inv",   1, 0, 0, 1, PAT_CHESS_INV,  128);
		set_row(6,  "up_bar_h",       1, 0, 0, 1, PAT_GRAY_BAR_H, 128);
		set_row(7,  "up_bar_v",       1, 0, 0, 1, PAT_GRAY_BAR_V, 128);
		set_row(8,  "up_gray192",     1, 0, 0, 1, PAT_GRAY192,    128);
		set_row(9,  "up_gray127",     1, 0, 0, 1, PAT_GRAY127,    128);
		set_row(10, "up_gray64",      1, 0, 0, 1, PAT_GRAY64,     128);
		set_row(11, "up_gray32",      1, 0, 0, 1, PAT_GRAY32,     128);
		set_row(12, "up_wrap",        1, 0, 0, 1, PAT_FRAME,      128);
		set_row(13, "down_wrap",      0, 1, 0, 1, PAT_GRAY32,     40);
		set_row(14, "both_keys",      0, 0, 1, 1, PAT_GRAY32,     40);
		// 88 to end of frame, one whole frame, then 20 into the next
		set_row(15, "key_mid_frame",  1, 0, 0, 0, PAT_GRAY32,     236);
		set_row(16, "flush_mid",      0, 0, 0, 1, PAT_FRAME,      64);
		set_row(17, "bar_v_2_frames", 7, 0, 0, 1, PAT_GRAY_BAR_V, 286);
		set_row(18, "down_bar_h",     0, 1, 0, 1, PAT_GRAY_BAR_H, 128);
	endtask

	function automatic pixel_t ref_pixel(pattern_e p, int cx, int cy);
		int    tw;
		int    th;
		logic  blk;
		gray_t g;
		tw  = H_ACT / CHESS_COLS;
		th  = V_ACT / CHESS_ROWS;
		blk = ((cx / tw) % 2) != ((cy / th) % 2);
		case (p)
			PAT_FRAME: return (cx == 0 || cx == H_ACT - 1 || cy == 0 || cy == V_ACT - 1) ?
				RGB_WHITE : RGB_BLACK;
			PAT_BLACK:     return RGB_BLACK;
			PAT_WHITE:     return RGB_WHITE;
			PAT_BLUE:      return RGB_BLUE;
			PAT_CHESS:     return blk ? RGB_BLACK : RGB_WHITE;
			PAT_CHESS_INV: return blk ? RGB_WHITE : RGB_BLACK;
			PAT_GRAY_BAR_H: g = gray_t'((cx / (H_ACT / BAR_STEPS)) * (256 / BAR_STEPS));
			PAT_GRAY_BAR_V: g = gray_t'((cy / (V_ACT / BAR_STEPS)) * (256 / BAR_STEPS));
			PAT_GRAY192:   g = 8'd192;
			PAT_GRAY127:   g = 8'd127;
			PAT_GRAY64:    g = 8'd64;
			default:       g = 8'd32;
		endcase
		return {g, g, g};
	endfunction

	task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s: expected %0h, actual %0h", what, exp, act);
			errors++;
		end
	endtask

	// inputs change 1 unit after the rising edge
	task automatic step_cycle;
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_key(bit up, bit down);
		key_up   = up;
		key_down = down;
		step_cycle();
		key_up   = 1'b0;
		key_down = 1'b0;
	endtask

	task automatic wait_first_pixel(string name);
		int k;
		k = 0;
		while (!out_valid && k < 4) begin
			step_cycle();
			k++;
		end
		if (!out_valid) begin
			$display("test %s: no pixel within 4 cycles of frame_start", name);
			errors++;
		end
	endtask

	task automatic read_pixels(string name, pattern_e p, int n);
		int got;
		int idle;
		bit ready;
		got  = 0;
		idle = 0;
		while (got < n && idle < PIX_WAIT) begin
			ready     = ({$random(seed)} % 10) < 6;
			out_ready = ready;
			if (out_valid && ready) begin
				check_value($sformatf("%s px(%0d,%0d)", name, px, py),
					32'(ref_pixel(p, px, py)), 32'(out_data));
				got++;
				idle = 0;
				px++;
				if (px == H_ACT) begin
					px = 0;
					py = (py == V_ACT - 1) ? 0 : py + 1;
				end
			end else begin
				idle++;
			end
			step_cycle();
		end
		out_ready = 1'b0;
		if (got < n) begin
			$display("test %s: timeout, no pixel arrived after %0d of %0d", name, got, n);
			errors++;
		end
	endtask

	task automatic run_test(int i);
		int err_before;
		int k;
		err_before = errors;
		for (k = 0; k < n_up[i]; k++) pulse_key(1'b1, 1'b0);
		for (k = 0; k < n_down[i]; k++) pulse_key(1'b0, 1'b1);
		if (both[i]) pulse_key(1'b1, 1'b1);
		if (fs[i]) begin
			frame_start = 1'b1;
			step_cycle();
			frame_start = 1'b0;
			px = 0;
			py = 0;
			check_value({tst_name[i], " flush"}, 32'd0, 32'(out_valid));
			wait_first_pixel(tst_name[i]);
		end
		check_value({tst_name[i], " pattern"}, 32'(exp_pat[i]),
			32'(i_pg_top.active_pattern));
		read_pixels(tst_name[i], exp_pat[i], n_pix[i]);
		if (errors == err_before) begin
			$display("test %s: ok, %0d pixels", tst_name[i], n_pix[i]);
		end else begin
			$display("test %s: %0d errors", tst_name[i], errors - err_before);
			failed++;
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		frame_start = 1'b0;
		key_up      = 1'b0;
		key_down    = 1'b0;
		out_ready   = 1'b0;
		seed        = 90281;
		errors      = 0;
		failed      = 0;
		px          = 0;
		py          = 0;
		load_table();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < N_TESTS; i++) begin
			run_test(i);
		end
		$display("tests %0d, failed %0d, errors %0d", N_TESTS, failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- bench/pg_props.sv
/* FIFO properties, bound into every pixel_fifo
   occupancy is rebuilt from the handshakes, CW wide like the FIFO's count */
module pg_props #(
	parameter int DEPTH = 16,
	parameter int CW    = $clog2(DEPTH) + 1
) (
	input logic clk,
	input logic rst_n,
	input logic flush,
	input logic wr_valid,
	input logic full,
	input logic rd_valid,
	input logic rd_ready
);

	// entries held, counted from accepted writes and reads
	logic [CW-1:0] occ;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			occ <= '0;
		end else if (flush) begin
			occ <= '0;
		end else begin
			occ <= occ + CW'(wr_valid && !full) - CW'(rd_valid && rd_ready);
		end
	end

	// a write into a full FIFO would lose a pixel
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(wr_valid && full))
		else $error("pixel written while FIFO full");

	a_valid_empty: assert property (@(posedge clk) disable iff (!rst_n)
		(occ == '0) |-> !rd_valid)
		else $error("rd_valid high with FIFO empty");

	// first edge after reset release
	a_reset_empty: assert property (@(posedge clk) $rose(rst_n) |-> !rd_valid)
		else $error("rd_valid high right after reset");

endmodule

bind pixel_fifo pg_props #(.DEPTH(FIFO_DEPTH)) i_pg_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.flush    (flush),
	.wr_valid (wr_valid),
	.full     (full),
	.rd_valid (rd_valid),
	.rd_ready (rd_ready)
);

//--- hw/pg_top.sv
/* test-pattern generator; H_ACT and V_ACT should divide by CHESS_COLS/ROWS and BAR_STEPS
   frame_start restarts the raster, flushes the FIFO and applies the selected pattern */
module pg_top import pg_pkg::*; #(
	parameter int H_ACT      = 1920,
	parameter int V_ACT      = 1080,
	parameter int CHESS_COLS = 8,
	parameter int CHESS_ROWS = 8,
	parameter int BAR_STEPS  = 32,
	parameter int FIFO_DEPTH = 16
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   frame_start,
	input  logic   key_up,
	input  logic   key_down,
	output pixel_t out_data,
	output logic   out_valid,
	input  logic   out_ready
);

	// tile sizes in pixels and lines
	localparam int CHESS_W = H_ACT / CHESS_COLS;
	localparam int CHESS_H = V_ACT / CHESS_ROWS;
	localparam int BAR_W   = H_ACT / BAR_STEPS;
	localparam int BAR_H   = V_ACT / BAR_STEPS;

	pattern_e  active_pattern;
	coord_t    x;
	coord_t    y;
	logic      coord_valid;
	logic      px_step;
	logic      line_wrap;
	logic      line_step;
	logic      frame_wrap;
	tile_idx_t chess_col;
	tile_idx_t chess_row;
	tile_idx_t bar_col;
	tile_idx_t bar_row;
	pixel_t    pix_data;
	logic      pix_valid;
	logic      has_room;

	pattern_select i_pattern_select (
		.clk            (clk),
		.rst_n          (rst_n),
		.frame_start    (frame_start),
		.key_up         (key_up),
		.key_down       (key_down),
		.active_pattern (active_pattern)
	);

	raster_counter #(.H_ACT(H_ACT), .V_ACT(V_ACT)) i_raster_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.has_room    (has_room),
		.x           (x),
		.y           (y),
		.coord_valid (coord_valid),
		.px_step     (px_step),
		.line_wrap   (line_wrap),
		.line_step   (line_step),
		.frame_wrap  (frame_wrap)
	);

	// horizontal dividers follow x, vertical ones follow y
	tile_divider #(.TILE(CHESS_W)) i_chess_col (
		.clk (clk), .rst_n (rst_n), .restart (line_wrap), .step (px_step), .index (chess_col)
	);

	tile_divider #(.TILE(CHESS_H)) i_chess_row (
		.clk (clk), .rst_n (rst_n), .restart (frame_wrap), .step (line_step), .index (chess_row)
	);

	tile_divider #(.TILE(BAR_W)) i_bar_col (
		.clk (clk), .rst_n (rst_n), .restart (line_wrap), .step (px_step), .index (bar_col)
	);

	tile_divider #(.TILE(BAR_H)) i_bar_row (
		.clk (clk), .rst_n (rst_n), .restart (frame_wrap), .step (line_step), .index (bar_row)
	);

	pattern_gen #(.H_ACT(H_ACT), .V_ACT(V_ACT), .BAR_STEPS(BAR_STEPS)) i_pattern_gen (
		.clk            (clk),
		.rst_n          (rst_n),
		.frame_start    (frame_start),
		.active_pattern (active_pattern),
		.x              (x),
		.y              (y),
		.coord_valid    (coord_valid),
		.chess_col      (chess_col),
		.chess_row      (chess_row),
		.bar_col        (bar_col),
		.bar_row        (bar_row),
		.pix_data       (pix_data),
		.pix_valid      (pix_valid)
	);

	pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .WIDTH($bits(pixel_t))) i_pixel_fifo (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (frame_start),
		.wr_data  (pix_data),
		.wr_valid (pix_valid),
		.rd_data  (out_data),
		.rd_valid (out_valid),
		.rd_ready (out_ready),
		.has_room (has_room)
	);

endmodule

//--- pixel_fifo/pixel_fifo.sv
/* register FIFO, head shown on rd_data while rd_valid; FIFO_DEPTH a power of two, >= 4
   has_room counts this cycle's write as taken; writes while full are dropped */
module pixel_fifo #(
	parameter int FIFO_DEPTH = 16,
	parameter int WIDTH      = 24
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             flush,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             wr_valid,
	output logic [WIDTH-1:0] rd_data,
	output logic             rd_valid,
	input  logic             rd_ready,
	output logic             has_room
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic [AW+1:0]    need;
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full     = (count == (AW+1)'(FIFO_DEPTH));
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];
	assign wr_en    = wr_valid & ~full;
	assign rd_en    = rd_valid & rd_ready;

	// room for the pending write plus two more in flight
	assign need     = (AW+2)'(count) + (AW+2)'(wr_valid) + (AW+2)'(2);
	assign has_room = (need <= (AW+2)'(FIFO_DEPTH));

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- hw/pattern_gen.sv
/* colour of pixel (x,y) for the active pattern, registered one cycle later
   tile indices must line up with x/y; BAR_STEPS is a power of two up to 256 */
module pattern_gen import pg_pkg::*; #(
	parameter int H_ACT     = 1920,
	parameter int V_ACT     = 1080,
	parameter int BAR_STEPS = 32
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      frame_start,
	input  pattern_e  active_pattern,
	input  coord_t    x,
	input  coord_t    y,
	input  logic      coord_valid,
	input  tile_idx_t chess_col,
	input  tile_idx_t chess_row,
	input  tile_idx_t bar_col,
	input  tile_idx_t bar_row,
	output pixel_t    pix_data,
	output logic      pix_valid
);

	// bar index times 256 / BAR_STEPS
	localparam int BAR_SHIFT = 8 - $clog2(BAR_STEPS);

	logic   on_border;
	logic   chess_black;
	gray_t  bar_gray_h;
	gray_t  bar_gray_v;
	pixel_t colour;

	assign on_border = (x == '0) || (x == coord_t'(H_ACT - 1)) ||
		(y == '0) || (y == coord_t'(V_ACT - 1));

	// tiles of differing parity are black
	assign chess_black = chess_col[0] ^ chess_row[0];

	assign bar_gray_h = gray_t'(bar_col << BAR_SHIFT);
	assign bar_gray_v = gray_t'(bar_row << BAR_SHIFT);

	always_comb begin
		case (active_pattern)
			PAT_FRAME:      colour = on_border ? RGB_WHITE : RGB_BLACK;
			PAT_BLACK:      colour = RGB_BLACK;
			PAT_WHITE:      colour = RGB_WHITE;
			PAT_BLUE:       colour = RGB_BLUE;
			PAT_CHESS:      colour = chess_black ? RGB_BLACK : RGB_WHITE;
			PAT_CHESS_INV:  colour = chess_black ? RGB_WHITE : RGB_BLACK;
			PAT_GRAY_BAR_H: colour = {3{bar_gray_h}};
			PAT_GRAY_BAR_V: colour = {3{bar_gray_v}};
			PAT_GRAY192:    colour = {3{GRAY_192}};
			PAT_GRAY127:    colour = {3{GRAY_127}};
			PAT_GRAY64:     colour = {3{GRAY_64}};
			PAT_GRAY32:     colour = {3{GRAY_32}};
			default:        colour = RGB_BLACK;
		endcase
	end

	always_ff @(posedge clk) begin
		if (coord_valid) begin
			pix_data <= colour;
		end
	end

	// frame_start drops whatever is in this stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= coord_valid & ~frame_start;
		end
	end

endmodule

//--- hw/pattern_select.sv
/* key_up and key_down are single-cycle pulses; both at once are ignored
   the selection reaches active_pattern only at frame_start */
module pattern_select import pg_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     frame_start,
	input  logic     key_up,
	input  logic     key_down,
	output pattern_e active_pattern
);

	pattern_e sel_pattern;
	pattern_e sel_next;

	always_comb begin
		sel_next = sel_pattern;
		if (key_up && !key_down) begin
			if (sel_pattern == PAT_LAST) begin
				sel_next = PAT_FIRST;
			end else begin
				sel_next = pattern_e'(sel_pattern + 5'd1);
			end
		end else if (key_down && !key_up) begin
			if (sel_pattern == PAT_FIRST) begin
				sel_next = PAT_LAST;
			end else begin
				sel_next = pattern_e'(sel_pattern - 5'd1);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_pattern <= PAT_DEFAULT;
		end else begin
			sel_pattern <= sel_next;
		end
	end

	// a key in the frame_start cycle only moves the selection
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active_pattern <= PAT_DEFAULT;
		end else if (frame_start) begin
			active_pattern <= sel_pattern;
		end
	end

endmodule

//--- hw/tile_divider.sv
/* counts steps into tiles of TILE positions, so index = coordinate / TILE
   TILE must be at least 1; index wraps silently past 255 */
module tile_divider import pg_pkg::*; #(
	parameter int TILE = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      restart,
	input  logic      step,
	output tile_idx_t index
);

	// position inside the current tile
	coord_t pos;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pos   <= '0;
			index <= '0;
		end else if (restart) begin
			pos   <= '0;
			index <= '0;
		end else if (step) begin
			if (pos == coord_t'(TILE - 1)) begin
				pos   <= '0;
				index <= index + 1'b1;
			end else begin
				pos <= pos + 1'b1;
			end
		end
	end

endmodule

//--- hw/raster_counter.sv
/* raster scan of H_ACT x V_ACT, one coordinate per cycle while has_room is high
   x/y hold the next coordinate; it is consumed on every edge with coord_valid high */
module raster_counter import pg_pkg::*; #(
	parameter int H_ACT = 1920,
	parameter int V_ACT = 1080
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   frame_start,
	input  logic   has_room,
	output coord_t x,
	output coord_t y,
	output logic   coord_valid,
	output logic   px_step,
	output logic   line_wrap,
	output logic   line_step,
	output logic   frame_wrap
);

	logic x_last;
	logic y_last;
	logic advance;

	assign x_last = (x == coord_t'(H_ACT - 1));
	assign y_last = (y == coord_t'(V_ACT - 1));

	// coordinate taken downstream this edge, so move on
	assign advance = coord_valid & ~frame_start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x           <= '0;
			y           <= '0;
			coord_valid <= 1'b0;
		end else if (frame_start) begin
			x           <= '0;
			y           <= '0;
			coord_valid <= 1'b0;
		end else begin
			coord_valid <= has_room;
			if (coord_valid) begin
				if (x_last) begin
					x <= '0;
					y <= y_last ? '0 : y + 1'b1;
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

	// divider strobes act on the same edge as x/y
	assign px_step    = advance & ~x_last;
	assign line_wrap  = frame_start | (advance & x_last);
	assign line_step  = advance & x_last & ~y_last;
	assign frame_wrap = frame_start | (advance & x_last & y_last);

endmodule

//--- common/pg_pkg.sv
/* shared types and constants of the pattern generator
   pattern_e order is the key stepping order, PAT_FIRST and PAT_LAST are its wrap ends */
package pg_pkg;

	// one colour channel
	typedef logic [7:0]  gray_t;

	// rgb pixel, red in the top byte
	typedef logic [23:0] pixel_t;

	// pixel or line position within the active raster
	typedef logic [11:0] coord_t;

	// tile index from the incremental dividers
	typedef logic [7:0]  tile_idx_t;

	typedef enum logic [4:0] {
		PAT_FRAME,
		PAT_BLACK,
		PAT_WHITE,
		PAT_BLUE,
		PAT_CHESS,
		PAT_CHESS_INV,
		PAT_GRAY_BAR_H,
		PAT_GRAY_BAR_V,
		PAT_GRAY192,
		PAT_GRAY127,
		PAT_GRAY64,
		PAT_GRAY32
	} pattern_e;

	localparam pattern_e PAT_FIRST   = PAT_FRAME;
	localparam pattern_e PAT_LAST    = PAT_GRAY32;
	localparam pattern_e PAT_DEFAULT = PAT_FRAME;

	localparam pixel_t RGB_BLACK = 24'h00_00_00;
	localparam pixel_t RGB_WHITE = 24'hff_ff_ff;
	localparam pixel_t RGB_BLUE  = 24'h00_00_ff;

	// flat gray levels, used on all three channels
	localparam gray_t GRAY_192 = 8'd192;
	localparam gray_t GRAY_127 = 8'd127;
	localparam gray_t GRAY_64  = 8'd64;
	localparam gray_t GRAY_32  = 8'd32;

endpackage
